//--- design/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// data word and byte address width
`define DC_WORD_W 32

// 8 sets, so 3 index bits
`define DC_SETS 8
`define DC_IDX_W 3

// 32 - idx(3) - blkoff(1) - bytoff(2)
`define DC_TAG_W 26

`define DC_WAYS 2      // two-way set associative
`define DC_BLK_WORDS 2 // words per block

`endif

//--- design/dcache_addr_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_addr_pkg;

   typedef logic [`DC_WORD_W-1:0] dcache_word_t; // one data word
   typedef logic [`DC_TAG_W-1:0]  dcache_tag_t;
   typedef logic [`DC_IDX_W-1:0]  dcache_idx_t;  // set select
   typedef logic                  dcache_way_t;  // way 0 or way 1

   // one byte address, read whole for the memory port
   // or split into fields for the set lookup
   typedef union packed
   {
      logic [`DC_WORD_W-1:0] raw; // memory side view
      struct packed
      {
         dcache_tag_t tag;    // compared against the stored tags
         dcache_idx_t idx;    // picks the set
         logic        blkoff; // word within the block
         logic [1:0]  bytoff; // word accesses only, so ignored
      } f;                    // lookup side view
   } dcache_addr_u;

endpackage

`default_nettype wire

//--- design/dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;

   // controller states
   typedef enum logic [2:0]
   {
      IDLE,    // hits answered here
      FETCH0,  // read word 0 of the missing block
      FETCH1,  // read word 1, then the block is valid
      WB0,     // write back word 0 of a dirty block
      WB1,     // write back word 1
      FLUSH,   // look for the next dirty block
      FLUSHED  // all clean, stays here
   } dc_state_e;

   // update command to the storage
   typedef enum logic [1:0]
   {
      NONE,    // only hit updates
      FILL_W0, // load word 0 into the lru way
      FILL_W1, // load word 1, set valid and tag, flip lru
      CLEAN    // clear dirty of the block being flushed
   } dc_fill_e;

endpackage

`default_nettype wire

//--- design/dcache_frames.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_frames
(
   input  logic                              CLK,
   input  logic                              nRST,
   input  dcache_addr_pkg::dcache_addr_u     addr,
   input  logic                              req,        // read or write present
   input  logic                              wr_hit,     // qualified by the controller
   input  dcache_addr_pkg::dcache_word_t     store_data,
   input  dcache_ctrl_pkg::dc_fill_e         fill_cmd,
   input  dcache_addr_pkg::dcache_word_t     fill_data,
   input  dcache_addr_pkg::dcache_idx_t      clean_idx,
   input  dcache_addr_pkg::dcache_way_t      clean_way,
   output logic                              hit,
   output dcache_addr_pkg::dcache_word_t     load_data,
   output logic                              victim_dirty,
   output dcache_addr_pkg::dcache_tag_t      victim_tag,
   output dcache_addr_pkg::dcache_word_t     victim_w0,
   output dcache_addr_pkg::dcache_word_t     victim_w1,
   output logic [`DC_SETS*`DC_WAYS-1:0]      dirty_vec,
   output dcache_addr_pkg::dcache_tag_t      flush_tag,
   output dcache_addr_pkg::dcache_word_t     flush_w0,
   output dcache_addr_pkg::dcache_word_t     flush_w1
);
   import dcache_addr_pkg::*;
   import dcache_ctrl_pkg::*;

   // per block control bits, set major
   logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
   logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
   logic [`DC_SETS-1:0]               lru_q;  // way to replace next

   dcache_tag_t  tag_q  [`DC_SETS][`DC_WAYS];
   dcache_word_t data_q [`DC_SETS][`DC_WAYS][`DC_BLK_WORDS];

   dcache_idx_t         idx;
   dcache_tag_t         tag;
   logic                off;
   logic [`DC_WAYS-1:0] way_hit;
   dcache_way_t         hit_way;
   dcache_way_t         lru_way;

   assign idx = addr.f.idx;
   assign tag = addr.f.tag;
   assign off = addr.f.blkoff;

   // tag compare on both ways of the set
   always_comb
   begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
      end
   end

   assign hit     = req && (|way_hit);
   assign hit_way = !way_hit[0]; // way 0 wins, else it must be way 1
   assign lru_way = lru_q[idx];

   assign load_data = data_q[idx][hit_way][off];

   // victim is always the lru way of the addressed set
   assign victim_dirty = dirty_q[idx][lru_way];
   assign victim_tag   = tag_q[idx][lru_way];
   assign victim_w0    = data_q[idx][lru_way][0];
   assign victim_w1    = data_q[idx][lru_way][1];

   // flush side reads the block the scanner picked
   assign flush_tag = tag_q[clean_idx][clean_way];
   assign flush_w0  = data_q[clean_idx][clean_way][0];
   assign flush_w1  = data_q[clean_idx][clean_way][1];

   assign dirty_vec = dirty_q; // bit idx*2+way

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
         lru_q   <= '0;
      end
      else
      begin
         case (fill_cmd)
            FILL_W0: valid_q[idx][lru_way] <= 1'b0; // half filled, no hits
            FILL_W1:
            begin
               valid_q[idx][lru_way] <= 1'b1;
               dirty_q[idx][lru_way] <= 1'b0;
               lru_q[idx]            <= !lru_way; // new block is most recent
            end
            CLEAN:   dirty_q[clean_idx][clean_way] <= 1'b0;
            default:
            begin
               if (wr_hit)
                  dirty_q[idx][hit_way] <= 1'b1;
               if (hit)
                  lru_q[idx] <= !hit_way; // the other way goes next
            end
         endcase
      end
   end

   // tags and words
   always_ff @(posedge CLK)
   begin
      case (fill_cmd)
         FILL_W0: data_q[idx][lru_way][0] <= fill_data;
         FILL_W1:
         begin
            data_q[idx][lru_way][1] <= fill_data;
            tag_q[idx][lru_way]     <= tag;
         end
         default:
         begin
            if (wr_hit)
               data_q[idx][hit_way][off] <= store_data;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/dcache_dirty_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_dirty_scan
(
   input  logic                          CLK,
   input  logic                          nRST,
   input  logic                          scan_en,   // high while in FLUSH
   input  logic [`DC_SETS*`DC_WAYS-1:0]  dirty_vec,
   output logic                          found,
   output dcache_addr_pkg::dcache_idx_t  scan_idx,
   output dcache_addr_pkg::dcache_way_t  scan_way
);
   import dcache_addr_pkg::*;

   logic [`DC_IDX_W:0] pick; // {set, way} of the first dirty block

   // lowest set first, way 0 before way 1
   // walk down so the lowest set bit is written last
   always_comb
   begin
      pick = '0;
      for (int i = `DC_SETS*`DC_WAYS-1; i >= 0; i--)
      begin
         if (dirty_vec[i])
            pick = i[`DC_IDX_W:0];
      end
   end

   // result held outside FLUSH so the write-back address stays put
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         found    <= 1'b0;
         scan_idx <= '0;
         scan_way <= 1'b0;
      end
      else if (scan_en)
      begin
         found    <= |dirty_vec;
         scan_idx <= pick[`DC_IDX_W:1];
         scan_way <= pick[0];
      end
   end

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
(
   input  logic                          CLK,
   input  logic                          nRST,
   input  logic                          halt,
   input  logic                          dmemREN,
   input  logic                          dmemWEN,
   input  dcache_addr_pkg::dcache_addr_u addr,
   input  logic                          hit,
   input  logic                          victim_dirty,
   input  dcache_addr_pkg::dcache_tag_t  victim_tag,
   input  dcache_addr_pkg::dcache_word_t victim_w0,
   input  dcache_addr_pkg::dcache_word_t victim_w1,
   input  dcache_addr_pkg::dcache_word_t flush_w0,
   input  dcache_addr_pkg::dcache_word_t flush_w1,
   input  dcache_addr_pkg::dcache_tag_t  flush_tag,
   input  logic                          found,
   input  dcache_addr_pkg::dcache_idx_t  scan_idx,
   input  dcache_addr_pkg::dcache_way_t  scan_way,
   input  logic                          dwait,
   output logic                          dhit,
   output logic                          wr_hit,
   output logic                          scan_en,
   output logic                          flushed,
   output logic                          dREN,
   output logic                          dWEN,
   output dcache_ctrl_pkg::dc_fill_e     fill_cmd,
   output dcache_addr_pkg::dcache_idx_t  clean_idx,
   output dcache_addr_pkg::dcache_way_t  clean_way,
   output dcache_addr_pkg::dcache_addr_u daddr,
   output dcache_addr_pkg::dcache_word_t dstore
);
   import dcache_addr_pkg::*;
   import dcache_ctrl_pkg::*;

   dc_state_e state_q, next_state;
   logic      flushing_q;  // write-backs come from the scanner, not the victim
   logic      scan_seen_q; // scanner result is current
   logic      req;

   assign req = dmemREN || dmemWEN;

   always_comb
   begin
      next_state = state_q;
      case (state_q)
         IDLE:
         begin
            if (halt)
               next_state = FLUSH;
            else if (req && !hit)
               next_state = victim_dirty ? WB0 : FETCH0; // dirty victim goes out first
         end
         FETCH0: if (!dwait) next_state = FETCH1;
         FETCH1: if (!dwait) next_state = IDLE;   // hit shows up next cycle
         WB0:    if (!dwait) next_state = WB1;
         WB1:    if (!dwait) next_state = flushing_q ? FLUSH : FETCH0;
         FLUSH:
         begin
            // one cycle for the scanner to register
            if (scan_seen_q)
               next_state = found ? WB0 : FLUSHED;
         end
         FLUSHED: next_state = FLUSHED;
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state_q     <= IDLE;
         flushing_q  <= 1'b0;
         scan_seen_q <= 1'b0;
      end
      else
      begin
         state_q     <= next_state;
         scan_seen_q <= (state_q == FLUSH) && (next_state == FLUSH);
         if (state_q == IDLE && halt)
            flushing_q <= 1'b1; // halt is final
      end
   end

   // processor side
   assign dhit    = (state_q == IDLE) && !halt && hit; // hit already needs a request
   assign wr_hit  = dhit && dmemWEN;
   assign flushed = (state_q == FLUSHED);
   assign scan_en = (state_q == FLUSH);

   // storage commands
   assign clean_idx = scan_idx;
   assign clean_way = scan_way;

   always_comb
   begin
      fill_cmd = NONE;
      if (!dwait)
      begin
         case (state_q)
            FETCH0:  fill_cmd = FILL_W0;
            FETCH1:  fill_cmd = FILL_W1;
            WB1:     fill_cmd = flushing_q ? CLEAN : NONE; // block now matches memory
            default: fill_cmd = NONE;
         endcase
      end
   end

   // memory side
   assign dREN = (state_q == FETCH0) || (state_q == FETCH1);
   assign dWEN = (state_q == WB0) || (state_q == WB1);

   always_comb
   begin
      daddr  = '0;
      dstore = '0;
      case (state_q)
         FETCH0, FETCH1:
         begin
            daddr.f.tag    = addr.f.tag;
            daddr.f.idx    = addr.f.idx;
            daddr.f.blkoff = (state_q == FETCH1); // word 0 then word 1
         end
         WB0, WB1:
         begin
            daddr.f.tag    = flushing_q ? flush_tag : victim_tag;
            daddr.f.idx    = flushing_q ? scan_idx : addr.f.idx;
            daddr.f.blkoff = (state_q == WB1);
            if (state_q == WB0)
               dstore = flushing_q ? flush_w0 : victim_w0;
            else
               dstore = flushing_q ? flush_w1 : victim_w1;
         end
         default: daddr = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
(
   input  logic                          CLK,
   input  logic                          nRST,
   input  logic                          halt,
   input  logic                          dmemREN,
   input  logic                          dmemWEN,
   input  dcache_addr_pkg::dcache_addr_u dmemaddr,
   input  dcache_addr_pkg::dcache_word_t dmemstore,
   output logic                          dhit,
   output dcache_addr_pkg::dcache_word_t dmemload,
   output logic                          flushed,
   output logic                          dREN,
   output logic                          dWEN,
   output dcache_addr_pkg::dcache_addr_u daddr,
   output dcache_addr_pkg::dcache_word_t dstore,
   input  dcache_addr_pkg::dcache_word_t dload,
   input  logic                          dwait
);
   import dcache_addr_pkg::*;
   import dcache_ctrl_pkg::*;

   logic                               req;
   logic                               hit, wr_hit;
   dc_fill_e                           fill_cmd;
   dcache_idx_t                        clean_idx, scan_idx;
   dcache_way_t                        clean_way, scan_way;
   logic                               victim_dirty;
   dcache_tag_t                        victim_tag, flush_tag;
   dcache_word_t                       victim_w0, victim_w1;
   dcache_word_t                       flush_w0, flush_w1;
   logic [`DC_SETS*`DC_WAYS-1:0]       dirty_vec;
   logic                               found, scan_en;

   assign req = dmemREN || dmemWEN; // any request present

   dcache_ctrl u_ctrl
   (
      .CLK(CLK), .nRST(nRST), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
      .addr(dmemaddr), .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
      .victim_w0(victim_w0), .victim_w1(victim_w1), .flush_w0(flush_w0),
      .flush_w1(flush_w1), .flush_tag(flush_tag), .found(found), .scan_idx(scan_idx),
      .scan_way(scan_way), .dwait(dwait), .dhit(dhit), .wr_hit(wr_hit),
      .scan_en(scan_en), .flushed(flushed), .dREN(dREN), .dWEN(dWEN),
      .fill_cmd(fill_cmd), .clean_idx(clean_idx), .clean_way(clean_way),
      .daddr(daddr), .dstore(dstore)
   );

   dcache_frames u_frames
   (
      .CLK(CLK), .nRST(nRST), .addr(dmemaddr), .req(req), .wr_hit(wr_hit),
      .store_data(dmemstore), .fill_cmd(fill_cmd), .fill_data(dload),
      .clean_idx(clean_idx), .clean_way(clean_way), .hit(hit), .load_data(dmemload),
      .victim_dirty(victim_dirty), .victim_tag(victim_tag), .victim_w0(victim_w0),
      .victim_w1(victim_w1), .dirty_vec(dirty_vec), .flush_tag(flush_tag),
      .flush_w0(flush_w0), .flush_w1(flush_w1)
   );

   dcache_dirty_scan u_scan
   (
      .CLK(CLK), .nRST(nRST), .scan_en(scan_en), .dirty_vec(dirty_vec),
      .found(found), .scan_idx(scan_idx), .scan_way(scan_way)
   );

endmodule

`default_nettype wire

//--- verification/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva
(
   input logic                          CLK,
   input logic                          nRST,
   input logic                          halt,
   input logic                          dhit,
   input logic                          flushed,
   input logic                          dREN,
   input logic                          dWEN,
   input logic                          dwait,
   input dcache_addr_pkg::dcache_addr_u daddr,
   input dcache_addr_pkg::dcache_word_t dstore
);

   // memory port moves one direction at a time
   a_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
      !(dREN && dWEN))
      else $error("dREN and dWEN are high in the same cycle");

   // back-pressure holds the word on the bus
   a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
      (dREN || dWEN) && dwait |=> $stable(daddr) && $stable(dstore))
      else $error("daddr or dstore changed while dwait was high");

   // flushed is final
   a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
      else $error("flushed dropped after it was set");

   a_no_hit_in_halt: assert property (@(posedge CLK) disable iff (!nRST)
      !(dhit && halt))
      else $error("dhit is high while halt is high");

endmodule

bind dcache_top dcache_sva u_sva
(
   .CLK(CLK), .nRST(nRST), .halt(halt), .dhit(dhit), .flushed(flushed),
   .dREN(dREN), .dWEN(dWEN), .dwait(dwait), .daddr(daddr), .dstore(dstore)
);

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;
   import dcache_addr_pkg::*;

   localparam int PERIOD    = 20;
   localparam int RESET_CYC = 5;
   localparam int MEM_WORDS = 256;  // byte addresses 0..1023
   localparam int N_RANDOM  = 200;
   localparam int N_OPS     = N_RANDOM + 16;  // directed accesses on top
   localparam int MISS_CYC  = 24;  // four words, up to 4 cycles each, plus request overhead
   localparam int FLUSH_CYC = `DC_SETS * `DC_WAYS * 12 + 20;
   localparam longint TIMEOUT_NS =
      longint'(RESET_CYC + N_OPS * MISS_CYC + FLUSH_CYC + 200) * PERIOD;

   logic         CLK = 1'b0;
   logic         nRST;
   logic         halt, dmemREN, dmemWEN;
   dcache_addr_u dmemaddr, daddr;
   dcache_word_t dmemstore, dmemload, dstore, dload;
   logic         dhit, flushed, dREN, dWEN;
   logic         dwait = 1'b0;

   dcache_word_t mem  [MEM_WORDS];  // memory model behind the cache
   dcache_word_t gold [MEM_WORDS];  // what memory must hold once everything is written back
   int unsigned  wait_cnt = 0;

   dcache_top u_dut
   (
      .CLK(CLK), .nRST(nRST), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
      .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload),
      .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
      .dload(dload), .dwait(dwait)
   );

   always #(PERIOD/2) CLK = ~CLK;

   // every word gets its own value, odd multiplier keeps them distinct
   function automatic dcache_word_t fill_word(input int unsigned i);
      return (i * 32'h9E3779B1) ^ 32'h5A5A5A5A;
   endfunction

   function automatic int unsigned word_index(input dcache_addr_u a);
      return 32'(a.raw[9:2]); // raw view, word address
   endfunction

   function automatic dcache_addr_u make_addr(input dcache_tag_t tag, input dcache_idx_t idx,
                                              input logic off);
      dcache_addr_u a;
      a.f.tag    = tag;
      a.f.idx    = idx;
      a.f.blkoff = off;
      a.f.bytoff = 2'b00;
      return a;
   endfunction

   assign dload = mem[word_index(daddr)]; // read data valid whenever dwait is low

   // memory model, each word waits 0 to 3 cycles
   always @(posedge CLK)
   begin
      int unsigned n;
      if (!nRST)
      begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= fill_word(i);
         wait_cnt <= 0;
         dwait    <= 1'b0;
      end
      else if ((dREN || dWEN) && dwait)
      begin
         if (wait_cnt == 1)
            dwait <= 1'b0; // word completes at the next edge
         wait_cnt <= wait_cnt - 1;
      end
      else
      begin
         if (dWEN)
            mem[word_index(daddr)] <= dstore; // write completes here
         n = $urandom_range(3, 0); // wait for the next word
         wait_cnt <= n;
         dwait    <= (n != 0);
      end
   end

   task automatic check_word(input string what, input dcache_word_t got,
                             input dcache_word_t exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "data word mismatch");
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   // one request held until dhit, cycles counts the miss wait
   task automatic access(input logic write, input dcache_addr_u a, input dcache_word_t wdata,
                         output dcache_word_t rdata, output int cycles);
      cycles = 0;
      @(posedge CLK);
      dmemREN   <= !write;
      dmemWEN   <= write;
      dmemaddr  <= a;
      dmemstore <= wdata;
      @(negedge CLK);
      while (!dhit)
      begin
         cycles++;
         @(negedge CLK);
      end
      rdata = dmemload;
      @(posedge CLK); // hit updates storage at this edge
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
   endtask

   task automatic read_expect(input dcache_addr_u a, input string what, output int cycles);
      dcache_word_t got;
      access(1'b0, a, '0, got, cycles);
      check_word(what, got, gold[word_index(a)]);
   endtask

   task automatic write_word(input dcache_addr_u a, input dcache_word_t d);
      dcache_word_t unused;
      int           cyc;
      access(1'b1, a, d, unused, cyc);
      gold[word_index(a)] = d;
   endtask

   task automatic test_read_miss_then_hit();
      int cyc;
      read_expect(make_addr(26'd1, 3'd2, 1'b0), "read miss word 0", cyc);
      read_expect(make_addr(26'd1, 3'd2, 1'b1), "read word 1 of same block", cyc);
      check_flag("word 1 hits at once", cyc == 0, 1'b1);
   endtask

   task automatic test_write_then_read();
      dcache_addr_u a;
      int           cyc;
      a = make_addr(26'd1, 3'd2, 1'b0);
      write_word(a, 32'hCAFE_0001);
      check_word("memory keeps old word", mem[word_index(a)], fill_word(word_index(a)));
      read_expect(a, "read after write", cyc);
      check_flag("read after write hits", cyc == 0, 1'b1);
   endtask

   // A and B fill set 5, A is reused, C must evict B
   task automatic test_lru_eviction();
      dcache_addr_u a, b, c;
      int           cyc;
      a = make_addr(26'd2, 3'd5, 1'b0);
      b = make_addr(26'd3, 3'd5, 1'b1);
      c = make_addr(26'd4, 3'd5, 1'b0);
      read_expect(a, "read A", cyc);
      write_word(b, 32'hB0B0_5EED);
      read_expect(a, "reread A", cyc);
      read_expect(c, "read C", cyc);
      read_expect(a, "read A after C", cyc);
      check_flag("A survives eviction", cyc == 0, 1'b1);
      check_word("B written back", mem[word_index(b)], gold[word_index(b)]);
   endtask

   // 8 tags over 2 sets, so blocks keep fighting for ways
   task automatic test_random_traffic();
      dcache_addr_u a;
      logic         wr;
      int           cyc;
      for (int k = 0; k < N_RANDOM; k++)
      begin
         a  = make_addr(dcache_tag_t'($urandom_range(7, 0)),
                        dcache_idx_t'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
         wr = 1'($urandom_range(1, 0));
         if (wr)
            write_word(a, $urandom());
         else
            read_expect(a, "random read", cyc);
      end
   endtask

   task automatic test_halt_flush();
      @(posedge CLK);
      halt     <= 1'b1;
      dmemREN  <= 1'b1; // cached block, halt alone must hold dhit low
      dmemaddr <= make_addr(26'd1, 3'd2, 1'b0);
      @(negedge CLK);
      check_flag("no dhit when halt rises", dhit, 1'b0); // still in IDLE here
      while (!flushed)
         @(negedge CLK);
      for (int i = 0; i < MEM_WORDS; i++)
         check_word("memory after flush", mem[i], gold[i]);
      repeat (10)
      begin
         @(negedge CLK);
         check_flag("flushed holds", flushed, 1'b1);
         check_flag("no dhit in halt", dhit, 1'b0);
      end
      @(posedge CLK);
      dmemREN <= 1'b0;
   endtask

   // hang guard
   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout, the cache stopped answering and the run hung");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      void'($urandom(36724));
      nRST      = 1'b0;
      halt      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         gold[i] = fill_word(i);
      repeat (RESET_CYC) @(posedge CLK);
      nRST <= 1'b1;
      test_read_miss_then_hit();
      test_write_then_read();
      test_lru_eviction();
      test_random_traffic();
      test_halt_flush();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/dcache_addr_pkg.sv
design/dcache_ctrl_pkg.sv
design/dcache_frames.sv
design/dcache_dirty_scan.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module dcache_tb -Mdir "$BUILD_DIR" -o dcache_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/dcache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
   exit 0
fi
exit 1
